// File: all.f
+incdir+logic
logic/instrPkg.sv
logic/threadPkg.sv
logic/regexIfs.sv
logic/instrMemory.sv
logic/threadQueue.sv
logic/regexCpu.sv
logic/regexEngine.sv
tests/regexEngine_checker.sv
tests/regexEngineTb.sv

// File: logic/instrMemory.sv
// program storage with a write port and a ready-valid fetch port
`include "regex_defines.svh"

module instrMemory
(
    input logic clk,
    input logic progWrite,
    input logic [`PC_WIDTH-1:0] progAddr,
    input logic [`MEM_WIDTH-1:0] progData,
    fetchIf.memory fetch
);
    localparam int words = 2 ** `PC_WIDTH;

    logic [`MEM_WIDTH-1:0] mem [words];

    // single-cycle array, never stalls a request
    assign fetch.ready = 1'b1;

    // program load
    always_ff @(posedge clk)
    begin
        if (progWrite)
        begin
            mem[progAddr] <= progData;
        end
    end

    // registered read data, valid the cycle after the accepted request
    always_ff @(posedge clk)
    begin
        if (fetch.valid && fetch.ready)
        begin
            fetch.data <= mem[fetch.addr];
        end
    end

endmodule

// File: logic/instrPkg.sv
// opcode enumeration and instruction struct of the regex program
`include "regex_defines.svh"

package instrPkg;

    typedef enum logic [2:0]
    {
        ACCEPT,
        ACCEPT_PARTIAL,
        SPLIT,
        MATCH,
        MATCH_ANY,
        JMP,
        END_WITHOUT_ACCEPTING
    } Opcode;

    // data holds a character for MATCH or a target pc for SPLIT and JMP
    typedef struct packed
    {
        Opcode op;
        logic [`CHAR_WIDTH-1:0] data;
    } Instr;

endpackage

// File: logic/regexCpu.sv
// thread execution FSM that fetches and executes one instruction per thread
`include "regex_defines.svh"

module regexCpu
    import instrPkg::*;
    import threadPkg::*;
(
    input logic clk,
    input logic rst,
    input logic [`CHAR_WIDTH*(2**`CC_ID_BITS)-1:0] chars,
    threadIf.sink inThread,
    fetchIf.requester fetch,
    threadIf.source outThread,
    output logic accepts,
    output logic running
);
    CpuState state;
    CpuState nextState;
    Thread curThread;
    Instr curInstr;
    logic [`CHAR_WIDTH-1:0] curChar;

    // outcome of the latched instruction
    logic execValid;
    logic execAccept;
    Thread execThread;
    CpuState execNext;

    // character under the thread's index
    assign curChar = chars[curThread.ccId*`CHAR_WIDTH +: `CHAR_WIDTH];

    always_comb
    begin
        execValid = 1'b0;
        execAccept = 1'b0;
        execThread.pc = curThread.pc + 1'b1;
        execThread.ccId = curThread.ccId;
        execNext = IDLE;
        case (curInstr.op)
            ACCEPT:
            begin
                // only a full match, the string must end here
                execAccept = (curChar == '0);
            end
            ACCEPT_PARTIAL:
            begin
                execAccept = 1'b1;
            end
            SPLIT:
            begin
                execValid = 1'b1;
                if (state == EXEC_1)
                begin
                    execNext = EXEC_2;
                end
                else
                begin
                    execThread.pc = curInstr.data;
                end
            end
            MATCH:
            begin
                if (curChar == curInstr.data)
                begin
                    execValid = 1'b1;
                    execThread.ccId = curThread.ccId + 1'b1;
                end
            end
            MATCH_ANY:
            begin
                execValid = 1'b1;
                execThread.ccId = curThread.ccId + 1'b1;
            end
            JMP:
            begin
                execValid = 1'b1;
                execThread.pc = curInstr.data;
            end
            default:
            begin
                // END_WITHOUT_ACCEPTING, thread dies
                execValid = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        nextState = state;
        inThread.ready = 1'b0;
        fetch.valid = 1'b0;
        outThread.valid = 1'b0;
        accepts = 1'b0;
        running = 1'b1;
        case (state)
            IDLE:
            begin
                running = 1'b0;
                inThread.ready = 1'b1;
                if (inThread.valid)
                begin
                    nextState = FETCH_SEND;
                end
            end
            FETCH_SEND:
            begin
                fetch.valid = 1'b1;
                if (fetch.ready)
                begin
                    nextState = FETCH_REC;
                end
            end
            FETCH_REC:
            begin
                nextState = EXEC_1;
            end
            EXEC_1, EXEC_2:
            begin
                outThread.valid = execValid;
                accepts = execAccept;
                // hold while the queue pushes back
                if (!execValid || outThread.ready)
                begin
                    nextState = execNext;
                end
            end
            default:
            begin
                nextState = IDLE;
            end
        endcase
    end

    // pc is steady from the pop until the next thread
    assign fetch.addr = curThread.pc;
    assign outThread.payload = execThread;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && inThread.valid)
        begin
            curThread <= inThread.payload;
        end
        if (state == FETCH_REC)
        begin
            curInstr <= Instr'(fetch.data[$bits(Instr)-1:0]);
        end
    end

endmodule

// File: logic/regexEngine.sv
// engine top level with run control, match flag and done detection
`include "regex_defines.svh"

module regexEngine
    import threadPkg::*;
(
    input logic clk,
    input logic rst,
    input logic progWrite,
    input logic [`PC_WIDTH-1:0] progAddr,
    input logic [`MEM_WIDTH-1:0] progData,
    input logic [`CHAR_WIDTH*(2**`CC_ID_BITS)-1:0] chars,
    input logic start,
    input logic [`PC_WIDTH-1:0] startPc,
    output logic busy,
    output logic done,
    output logic matched
);
    logic seedValid;
    Thread seed;
    logic queueEmpty;
    logic cpuRunning;
    logic cpuAccepts;
    logic pushing;
    logic runEnd;

    threadIf popIf ();
    threadIf contIf ();
    fetchIf fetchBus ();

    // a start is taken only between runs
    assign seedValid = start && !busy;
    assign seed.pc = startPc;
    assign seed.ccId = '0;

    assign pushing = seedValid || (contIf.valid && contIf.ready);

    // nothing queued, nothing executing and nothing on its way in
    assign runEnd = busy && queueEmpty && !cpuRunning && !pushing;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            matched <= 1'b0;
        end
        else
        begin
            done <= runEnd;
            if (seedValid)
            begin
                busy <= 1'b1;
            end
            else if (runEnd)
            begin
                busy <= 1'b0;
            end
            if (seedValid)
            begin
                matched <= 1'b0;
            end
            else if (cpuAccepts)
            begin
                matched <= 1'b1;
            end
        end
    end

    instrMemory memory
    (
        .clk(clk),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .fetch(fetchBus)
    );

    threadQueue queue
    (
        .clk(clk),
        .rst(rst),
        .seedValid(seedValid),
        .seed(seed),
        .cont(contIf),
        .pop(popIf),
        .empty(queueEmpty)
    );

    regexCpu cpu
    (
        .clk(clk),
        .rst(rst),
        .chars(chars),
        .inThread(popIf),
        .fetch(fetchBus),
        .outThread(contIf),
        .accepts(cpuAccepts),
        .running(cpuRunning)
    );

endmodule

// File: logic/regexIfs.sv
// threadIf and fetchIf interfaces with their modports
`include "regex_defines.svh"

// ready-valid channel carrying one thread
interface threadIf
    import threadPkg::*;
();
    logic valid;
    logic ready;
    Thread payload;

    modport source (output valid, output payload, input ready);
    modport sink (input valid, input payload, output ready);
endinterface

// instruction fetch channel, data answers one cycle after the request
interface fetchIf ();
    logic valid;
    logic ready;
    logic [`PC_WIDTH-1:0] addr;
    logic [`MEM_WIDTH-1:0] data;

    modport requester
    (
        output valid,
        output addr,
        input ready,
        input data
    );
    modport memory
    (
        input valid,
        input addr,
        output ready,
        output data
    );
endinterface

// File: logic/regex_defines.svh
// width macros for program counter, character index, character, memory word and queue depth
`ifndef REGEX_DEFINES_SVH
`define REGEX_DEFINES_SVH

// program counter, also the instruction memory address
`define PC_WIDTH 8

// character index inside the window, four characters
`define CC_ID_BITS 2

`define CHAR_WIDTH 8

// instruction memory word, instruction sits in the low bits
`define MEM_WIDTH 16

// pending thread entries
`define QUEUE_DEPTH 8

`endif

// File: logic/threadPkg.sv
// thread struct and CPU state enumeration
`include "regex_defines.svh"

package threadPkg;

    typedef struct packed
    {
        logic [`PC_WIDTH-1:0] pc;
        logic [`CC_ID_BITS-1:0] ccId;
    } Thread;

    typedef enum logic [2:0]
    {
        IDLE,
        FETCH_SEND,
        FETCH_REC,
        EXEC_1,
        EXEC_2
    } CpuState;

endpackage

// File: logic/threadQueue.sv
// circular FIFO of pending threads with a seed and continuation push arbiter
`include "regex_defines.svh"

module threadQueue
    import threadPkg::*;
(
    input logic clk,
    input logic rst,
    input logic seedValid,
    input Thread seed,
    threadIf.sink cont,
    threadIf.source pop,
    output logic empty
);
    localparam int ptrWidth = $clog2(`QUEUE_DEPTH);
    localparam int countWidth = $clog2(`QUEUE_DEPTH + 1);
    localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(`QUEUE_DEPTH - 1);

    Thread buffer [`QUEUE_DEPTH];
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic [countWidth-1:0] count;
    logic pushFire;
    logic popFire;
    Thread pushData;

    // the seed wins, it only arrives while the engine is idle
    assign pushFire = seedValid || (cont.valid && cont.ready);
    assign pushData = seedValid ? seed : cont.payload;
    assign popFire = pop.valid && pop.ready;

    assign cont.ready = (count != countWidth'(`QUEUE_DEPTH));
    assign pop.valid = (count != '0);
    assign pop.payload = buffer[rdPtr];
    assign empty = (count == '0);

    always_ff @(posedge clk)
    begin
        if (pushFire)
        begin
            buffer[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (pushFire)
            begin
                wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (popFire)
            begin
                rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            end
            case ({pushFire, popFire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the regex engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module regexEngineTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

# keep running past assertion errors so the testbench can count them
./obj_dir/VregexEngineTb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tests/regexEngineTb.sv
// testbench for the regex engine with directed, random and reset tests
`include "regex_defines.svh"

module regexEngineTb
    import instrPkg::*;
();
    localparam int numTests = 35;
    localparam int windowBits = `CHAR_WIDTH * (2 ** `CC_ID_BITS);

    logic clk;
    logic rst;
    logic progWrite;
    logic [`PC_WIDTH-1:0] progAddr;
    logic [`MEM_WIDTH-1:0] progData;
    logic [windowBits-1:0] chars;
    logic start;
    logic [`PC_WIDTH-1:0] startPc;
    logic busy;
    logic done;
    logic matched;
    int passes = 0;
    int errors = 0;

    regexEngine DUT
    (
        .clk(clk),
        .rst(rst),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .chars(chars),
        .start(start),
        .startPc(startPc),
        .busy(busy),
        .done(done),
        .matched(matched)
    );

    bind regexEngine regexEngine_checker checks
    (
        .clk(clk),
        .rst(rst),
        .done(done),
        .matched(matched),
        .cpuAccepts(cpuAccepts),
        .queueEmpty(queueEmpty),
        .cpuRunning(cpuRunning),
        .fetchValid(fetchBus.valid),
        .fetchReady(fetchBus.ready),
        .fetchAddr(fetchBus.addr),
        .queueCount(queue.count)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        repeat (numTests * 200) @(posedge clk);
        $display("watchdog expired because a run never signaled done");
        $display("Finished with errors");
        $finish;
    end

    task automatic writeInstr(input logic [`PC_WIDTH-1:0] addr, input Opcode op,
                              input logic [`CHAR_WIDTH-1:0] data);
        @(posedge clk);
        #1;
        progWrite = 1'b1;
        progAddr = addr;
        progData = `MEM_WIDTH'({op, data});
    endtask

    // programs sit at separate bases and are picked by startPc
    task automatic loadPrograms();
        // literal ab at 0
        writeInstr(8'd0, MATCH, "a");
        writeInstr(8'd1, MATCH, "b");
        writeInstr(8'd2, ACCEPT, 8'd0);
        // a|b at 8
        writeInstr(8'd8, SPLIT, 8'd11);
        writeInstr(8'd9, MATCH, "a");
        writeInstr(8'd10, ACCEPT, 8'd0);
        writeInstr(8'd11, MATCH, "b");
        writeInstr(8'd12, ACCEPT, 8'd0);
        // a*b at 16
        writeInstr(8'd16, SPLIT, 8'd19);
        writeInstr(8'd17, MATCH, "a");
        writeInstr(8'd18, JMP, 8'd16);
        writeInstr(8'd19, MATCH, "b");
        writeInstr(8'd20, ACCEPT, 8'd0);
        // wildcard then partial accept at 24, full accept at 28
        writeInstr(8'd24, MATCH_ANY, 8'd0);
        writeInstr(8'd25, ACCEPT_PARTIAL, 8'd0);
        writeInstr(8'd28, MATCH_ANY, 8'd0);
        writeInstr(8'd29, ACCEPT, 8'd0);
        writeInstr(8'd32, END_WITHOUT_ACCEPTING, 8'd0);
        // accepts early, then the split at 42 keeps adding threads until the queue is full
        writeInstr(8'd40, SPLIT, 8'd42);
        writeInstr(8'd41, ACCEPT_PARTIAL, 8'd0);
        writeInstr(8'd42, SPLIT, 8'd42);
        writeInstr(8'd43, JMP, 8'd42);
        @(posedge clk);
        #1;
        progWrite = 1'b0;
    endtask

    function automatic logic [windowBits-1:0] packChars(input string text);
        logic [windowBits-1:0] word;
        word = '0;
        for (int i = 0; i < 3 && i < text.len(); i++)
        begin
            word[i*`CHAR_WIDTH +: `CHAR_WIDTH] = text[i];
        end
        return word;
    endfunction

    // zero or more a, one b, then the terminator
    function automatic logic isAStarB(input logic [windowBits-1:0] word);
        int i;
        i = 0;
        while (i < 3 && word[i*`CHAR_WIDTH +: `CHAR_WIDTH] == "a")
        begin
            i++;
        end
        if (i > 2)
        begin
            return 1'b0;
        end
        return word[i*`CHAR_WIDTH +: `CHAR_WIDTH] == "b"
            && word[(i+1)*`CHAR_WIDTH +: `CHAR_WIDTH] == 8'd0;
    endfunction

    task automatic checkValue(input string name, input logic expected, input logic actual);
        assert (actual == expected)
        begin
            passes++;
            $display("PASS %s", name);
        end
        else
        begin
            errors++;
            $display("FAIL %s expected %0b actual %0b", name, expected, actual);
        end
    endtask

    task automatic runTest(input string name, input logic [`PC_WIDTH-1:0] entry,
                           input logic [windowBits-1:0] word, input logic expected);
        @(posedge clk);
        #1;
        chars = word;
        startPc = entry;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!done);
        checkValue(name, expected, matched);
    endtask

    initial
    begin
        logic [windowBits-1:0] word;
        int len;
        rst = 1'b1;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        chars = '0;
        start = 1'b0;
        startPc = '0;
        void'($urandom(32'h5652));
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        loadPrograms();

        runTest("literal ab", 8'd0, packChars("ab"), 1'b1);
        runTest("literal ax", 8'd0, packChars("ax"), 1'b0);
        runTest("alternation a", 8'd8, packChars("a"), 1'b1);
        runTest("alternation b", 8'd8, packChars("b"), 1'b1);
        runTest("alternation c", 8'd8, packChars("c"), 1'b0);
        runTest("loop b", 8'd16, packChars("b"), 1'b1);
        runTest("loop ab", 8'd16, packChars("ab"), 1'b1);
        runTest("loop aab", 8'd16, packChars("aab"), 1'b1);
        runTest("loop aa", 8'd16, packChars("aa"), 1'b0);
        // partial accept ignores what follows, full accept needs the terminator
        runTest("wildcard partial xy", 8'd24, packChars("xy"), 1'b1);
        runTest("wildcard full xy", 8'd28, packChars("xy"), 1'b0);
        runTest("end without accepting", 8'd32, packChars("abc"), 1'b0);

        for (int n = 0; n < 20; n++)
        begin
            word = '0;
            len = $urandom_range(3, 0);
            for (int i = 0; i < len; i++)
            begin
                word[i*`CHAR_WIDTH +: `CHAR_WIDTH] = 8'("a" + $urandom_range(2, 0));
            end
            runTest($sformatf("random %0d", n), 8'd16, word, isAStarB(word));
        end

        // reset a run that has already matched and never ends on its own
        @(posedge clk);
        #1;
        chars = packChars("a");
        startPc = 8'd40;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!matched);
        // long enough for the queue to fill and the CPU to stall on it
        repeat (200) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue("reset clears busy", 1'b0, busy);
        checkValue("reset clears matched", 1'b0, matched);
        runTest("run after reset", 8'd0, packChars("ab"), 1'b1);

        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                 passes + errors, passes, errors, DUT.checks.failCount);
        if (errors == 0 && DUT.checks.failCount == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tests/regexEngine_checker.sv
// concurrent assertions on fetch protocol, queue pushes, match flag and done
`include "regex_defines.svh"

module regexEngine_checker
(
    input logic clk,
    input logic rst,
    input logic done,
    input logic matched,
    input logic cpuAccepts,
    input logic queueEmpty,
    input logic cpuRunning,
    input logic fetchValid,
    input logic fetchReady,
    input logic [`PC_WIDTH-1:0] fetchAddr,
    input logic [$clog2(`QUEUE_DEPTH+1)-1:0] queueCount
);
    // read by the testbench at the end of the run
    int failCount = 0;

    // done comes from a register, so skip the first reset cycle
    doneInReset: assert property (@(posedge clk) rst && $past(rst) |-> !done)
    else
    begin
        failCount++;
        $error("done was high while reset was held");
    end

    fetchHold: assert property (@(posedge clk) disable iff (rst)
        fetchValid && !fetchReady |=> fetchValid && $stable(fetchAddr))
    else
    begin
        failCount++;
        $error("fetch request dropped or its address moved before ready");
    end

    matchedNeedsAccept: assert property (@(posedge clk) disable iff (rst)
        $rose(matched) |-> $past(cpuAccepts))
    else
    begin
        failCount++;
        $error("matched rose without the CPU accepting a thread");
    end

    // a continuation taken while full would carry the count past the depth
    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        queueCount <= `QUEUE_DEPTH)
    else
    begin
        failCount++;
        $error("continuation pushed into a full thread queue");
    end

    doneWhenIdle: assert property (@(posedge clk) disable iff (rst)
        done |-> queueEmpty && !cpuRunning)
    else
    begin
        failCount++;
        $error("done strobed while threads were still pending or running");
    end

endmodule
